// ==== tb.f ====
rtl/aluPkg.sv
rtl/opDecoder.sv
rtl/carryLookahead.sv
rtl/aluCore.sv
rtl/flagRegister.sv
rtl/aluUnit.sv
tests/tbClock.sv
tests/aluTb.sv

// ==== Bender.yml ====
package:
  name: sm83_alu

sources:
  - files:
      - rtl/aluPkg.sv
      - rtl/opDecoder.sv
      - rtl/carryLookahead.sv
      - rtl/aluCore.sv
      - rtl/flagRegister.sv
      - rtl/aluUnit.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/aluTb.sv

// ==== tests/aluTb.sv ====
`timescale 1ns/1ps

module aluTb import aluPkg::*; ();

	logic CLK;
	logic rstN;
	logic req;
	logic cbPrefix;
	logic [dataWidth-1:0] opcode;
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic ack;
	logic [dataWidth-1:0] result;
	logic [flagWidth-1:0] flags;

	int seed = 32'h21435a7a;
	int passCount = 0;
	int failCount = 0;
	bit timedOut = 0;
	logic [36:0] stimQ[$];	// {cbPrefix, opcode, A, B, result, flags}
	int holdQ[$];	// Extra cycles req stays high past ack

	tbClock clockGen (.CLK(CLK), .rstN(rstN));

	aluUnit uut (
		.CLK(CLK),
		.rstN(rstN),
		.req(req),
		.cbPrefix(cbPrefix),
		.opcode(opcode),
		.operandA(operandA),
		.operandB(operandB),
		.ack(ack),
		.result(result),
		.flags(flags)
	);

	task automatic addCase(input logic cb, input logic [7:0] opc, a, b, res,
			input logic [3:0] fl, input int hold);
		stimQ.push_back({cb, opc, a, b, res, fl});
		holdQ.push_back(hold);
	endtask

	// Independent ADD/SUB model built from the flag rules
	function automatic logic [11:0] addSubModel(input logic isSub, input logic [7:0] a, b);
		logic [8:0] full;
		logic [3:0] fl;
		if (isSub) begin
			full = {1'b0, a} - {1'b0, b};
			fl[flagH] = a[3:0] < b[3:0];	// Borrow from bit 4
			fl[flagC] = a < b;
		end else begin
			full = {1'b0, a} + {1'b0, b};
			fl[flagH] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'h0f;
			fl[flagC] = full[8];
		end
		fl[flagZ] = full[7:0] == 8'h00;
		fl[flagN] = isSub;
		return {full[7:0], fl};
	endfunction

	task automatic waitAck(input logic level, input int testId);
		int cycles;
		cycles = 0;
		while (ack !== level && cycles < 20) begin
			@(negedge CLK);
			cycles++;
		end
		if (ack !== level) begin
			$display("Test %0d: ack did not go to %0b within 20 cycles", testId, level);
			timedOut = 1;
		end
	endtask

	task automatic checkOutputs(input int testId, input logic [7:0] expRes,
			input logic [3:0] expFlags, inout bit ok);
		if (result !== expRes) begin
			$display("** Error test %0d: result expected %h got %h", testId, expRes, result);
			ok = 0;
		end
		if (flags !== expFlags) begin
			$display("** Error test %0d: flags expected %h got %h", testId, expFlags, flags);
			ok = 0;
		end
	endtask

	task automatic runOp(input int testId, input logic [36:0] entry, input int hold);
		bit ok;
		ok = 1;
		@(posedge CLK);
		cbPrefix <= entry[36];
		opcode <= entry[35:28];
		operandA <= entry[27:20];
		operandB <= entry[19:12];
		req <= 1'b1;
		@(negedge CLK);
		if (ack !== 1'b0) begin	// Must lag req by one edge
			$display("** Error test %0d: ack expected 0 got %h", testId, ack);
			ok = 0;
		end
		waitAck(1'b1, testId);
		if (!timedOut) begin
			checkOutputs(testId, entry[11:4], entry[3:0], ok);
			repeat (hold) begin
				@(negedge CLK);
				if (ack !== 1'b1) begin
					$display("** Error test %0d: ack expected 1 got %h", testId, ack);
					ok = 0;
				end
				checkOutputs(testId, entry[11:4], entry[3:0], ok);
			end
			@(posedge CLK);
			req <= 1'b0;
			@(negedge CLK);
			waitAck(1'b0, testId);
		end
		if (timedOut)
			ok = 0;
		if (ok) begin
			passCount++;
			$display("Test %0d passed", testId);
		end else begin
			failCount++;
			$display("Test %0d failed", testId);
		end
	endtask

	initial begin
		int idx;
		int cycles;
		bit ok;
		logic [7:0] a;
		logic [7:0] b;
		logic isSub;
		logic [11:0] expected;
		req = 1'b0;
		cbPrefix = 1'b0;
		opcode = '0;
		operandA = '0;
		operandB = '0;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < 20) begin
			@(negedge CLK);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			$display("Reset was never released");
			timedOut = 1;
		end
		@(negedge CLK);
		ok = 1;
		if (ack !== 1'b0) begin
			$display("** Error test 0: ack expected 0 got %h", ack);
			ok = 0;
		end
		checkOutputs(0, 8'h00, 4'h0, ok);
		if (ok) begin
			passCount++;
			$display("Test 0 passed");
		end else begin
			failCount++;
			$display("Test 0 failed");
		end

		addCase(1'b0, 8'h80, 8'h3a, 8'hc6, 8'h00, 4'hb, 0);	// ADD to zero, H and C
		addCase(1'b0, 8'h88, 8'h0f, 8'h01, 8'h11, 4'h2, 0);	// ADC with stored C
		addCase(1'b0, 8'h80, 8'h0f, 8'h01, 8'h10, 4'h2, 0);
		addCase(1'b0, 8'h80, 8'hf0, 8'h20, 8'h10, 4'h1, 0);	// Carry only
		addCase(1'b0, 8'h98, 8'h10, 8'h01, 8'h0e, 4'h6, 0);	// SBC with stored C
		addCase(1'b0, 8'h90, 8'h3e, 8'h3e, 8'h00, 4'hc, 0);
		addCase(1'b0, 8'h90, 8'h3e, 8'h40, 8'hfe, 4'h5, 0);	// Full borrow
		addCase(1'b0, 8'h98, 8'h3b, 8'h2a, 8'h10, 4'h4, 0);
		addCase(1'b0, 8'hb8, 8'h3c, 8'h2f, 8'h3c, 4'h6, 0);	// CP keeps A
		addCase(1'b0, 8'hb8, 8'h3c, 8'h3c, 8'h3c, 4'hc, 0);
		addCase(1'b0, 8'ha0, 8'h5a, 8'h3c, 8'h18, 4'h2, 0);	// AND
		addCase(1'b0, 8'ha0, 8'hf0, 8'h0f, 8'h00, 4'ha, 0);
		addCase(1'b0, 8'ha8, 8'hff, 8'hff, 8'h00, 4'h8, 0);	// XOR
		addCase(1'b0, 8'hb0, 8'h50, 8'h0a, 8'h5a, 4'h0, 0);	// OR
		addCase(1'b1, 8'h00, 8'h00, 8'h85, 8'h0b, 4'h1, 0);	// RLC
		addCase(1'b1, 8'h10, 8'h00, 8'h80, 8'h01, 4'h1, 0);	// RL takes C in
		addCase(1'b1, 8'h18, 8'h00, 8'h01, 8'h80, 4'h1, 0);	// RR takes C in
		addCase(1'b1, 8'h08, 8'h00, 8'h01, 8'h80, 4'h1, 0);	// RRC
		addCase(1'b1, 8'h20, 8'h00, 8'h80, 8'h00, 4'h9, 0);	// SLA
		addCase(1'b1, 8'h28, 8'h00, 8'h8a, 8'hc5, 4'h0, 0);	// SRA
		addCase(1'b1, 8'h38, 8'h00, 8'h01, 8'h00, 4'h9, 0);	// SRL
		addCase(1'b1, 8'h30, 8'h00, 8'hf1, 8'h1f, 4'h0, 0);	// SWAP clears C
		addCase(1'b1, 8'h10, 8'h00, 8'h7f, 8'hfe, 4'h0, 0);
		addCase(1'b0, 8'h80, 8'hff, 8'h01, 8'h00, 4'hb, 0);	// Sets C before BIT
		addCase(1'b1, 8'h78, 8'h00, 8'h7f, 8'h7f, 4'hb, 0);	// BIT 7, C kept
		addCase(1'b1, 8'h40, 8'h00, 8'h01, 8'h01, 4'h3, 0);	// BIT 0
		addCase(1'b1, 8'h98, 8'h00, 8'hff, 8'hf7, 4'h3, 0);	// RES 3
		addCase(1'b1, 8'hf0, 8'h00, 8'h00, 8'h40, 4'h3, 0);	// SET 6
		addCase(1'b0, 8'h00, 8'h5a, 8'h12, 8'h5a, 4'h3, 0);	// Undecoded, passes A
		addCase(1'b0, 8'h88, 8'h12, 8'h34, 8'h47, 4'h0, 4);	// ADC with req held past ack

		for (idx = 0; idx < stimQ.size() && !timedOut; idx++)
			runOp(idx + 1, stimQ[idx], holdQ[idx]);

		for (idx = 0; idx < 40 && !timedOut; idx++) begin
			a = $random(seed);
			b = $random(seed);
			isSub = $random(seed);
			expected = addSubModel(isSub, a, b);
			runOp(stimQ.size() + idx + 1, {1'b0, isSub ? 8'h90 : 8'h80, a, b, expected}, 0);
		end

		$display("Tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && !timedOut)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;	// 100 ns period
	end

	// Reset low through the first five rising edges
	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import aluPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic req,
	input logic cbPrefix,
	input logic [dataWidth-1:0] opcode,
	input logic [dataWidth-1:0] operandA,
	input logic [dataWidth-1:0] operandB,
	output logic ack,
	output logic [dataWidth-1:0] result,
	output logic [flagWidth-1:0] flags
);

	typedef enum logic {stIdle, stAck} ctrlState;

	ctrlState state;
	logic load;	// High in the cycle before the accepting edge
	aluOp op;
	logic [2:0] bitIndex;
	logic [dataWidth-1:0] nextResult;
	logic [flagWidth-1:0] nextFlags;
	logic [flagWidth-1:0] flagMask;
	logic carry;

	opDecoder decoder (
		.cbPrefix(cbPrefix),
		.opcode(opcode),
		.op(op),
		.bitIndex(bitIndex)
	);

	// Operands are held by the host while req is up
	aluCore core (
		.op(op),
		.bitIndex(bitIndex),
		.operandA(operandA),
		.operandB(operandB),
		.carry(carry),
		.nextResult(nextResult),
		.nextFlags(nextFlags),
		.flagMask(flagMask)
	);

	flagRegister flagRegs (
		.CLK(CLK),
		.rstN(rstN),
		.load(load),
		.nextFlags(nextFlags),
		.flagMask(flagMask),
		.flags(flags),
		.carry(carry)
	);

	assign load = (state == stIdle) && req;
	assign ack = (state == stAck);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: if (req) state <= stAck;
				default: if (!req) state <= stIdle;	// Wait for req to drop
			endcase
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
		end else if (load) begin
			result <= nextResult;
		end
	end

	ackNeedsReq: assert property (@(posedge CLK) disable iff (!rstN) $rose(ack) |-> $past(req))
		else $error("ack rose without a request");

	resultHeld: assert property (@(posedge CLK) disable iff (!rstN) ack |=> $stable(result))
		else $error("result changed while ack was high");

endmodule

// ==== rtl/flagRegister.sv ====
`timescale 1ns/1ps

module flagRegister import aluPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic load,	// Accept strobe from controller
	input logic [flagWidth-1:0] nextFlags,
	input logic [flagWidth-1:0] flagMask,	// 1 = flag written
	output logic [flagWidth-1:0] flags,
	output logic carry
);

	logic [flagWidth-1:0] flagsQ;
	logic [flagWidth-1:0] flagsD;

	// Unmasked flags keep their stored value
	assign flagsD = (flagsQ & ~flagMask) | (nextFlags & flagMask);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else if (load) begin
			flagsQ <= flagsD;
		end
	end

	assign flags = flagsQ;
	assign carry = flagsQ[flagC];	// Feeds ADC, SBC, RL, RR

	property flagsHoldWithoutLoad;
		@(posedge CLK) disable iff (!rstN)
		!load |=> $stable(flagsQ);
	endproperty

	flagsHold: assert property (flagsHoldWithoutLoad)
		else $error("Flags changed without a load strobe");

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/1ps

module aluCore import aluPkg::*; (
	input aluOp op,
	input logic [2:0] bitIndex,
	input logic [dataWidth-1:0] operandA,
	input logic [dataWidth-1:0] operandB,
	input logic carry,	// Stored C flag
	output logic [dataWidth-1:0] nextResult,
	output logic [flagWidth-1:0] nextFlags,
	output logic [flagWidth-1:0] flagMask
);

	logic subtract;
	logic carryIn;
	logic [dataWidth-1:0] bOperand;	// B, inverted for subtraction
	logic [dataWidth-1:0] genBits;
	logic [dataWidth-1:0] propBits;
	logic [dataWidth:0] carries;	// carries[i] goes into bit i
	logic [dataWidth-1:0] sum;
	logic [dataWidth:0] sumCheck;
	logic [dataWidth-1:0] bitMask;
	logic [dataWidth-1:0] zeroSrc;	// Value whose zero-ness gives Z
	logic nFlag;
	logic hFlag;
	logic cFlag;

	assign subtract = (op == opSub) || (op == opSbc) || (op == opCp);
	assign bOperand = subtract ? ~operandB : operandB;
	assign genBits = operandA & bOperand;
	assign propBits = operandA ^ bOperand;

	always_comb begin
		case (op)
			opAdc: carryIn = carry;
			opSub, opCp: carryIn = 1'b1;	// Two's complement +1
			opSbc: carryIn = ~carry;	// Inverted borrow-in
			default: carryIn = 1'b0;
		endcase
	end

	assign carries[0] = carryIn;

	carryLookahead cclaLow (
		.genTerm(genBits[3:0]),
		.propTerm(propBits[3:0]),
		.carryIn(carries[0]),
		.carryOut(carries[4:1])
	);

	carryLookahead claHigh (
		.genTerm(genBits[7:4]),
		.propTerm(propBits[7:4]),
		.carryIn(carries[4]),	// Chained from low nibble
		.carryOut(carries[8:5])
	);

	assign sum = propBits ^ carries[dataWidth-1:0];
	assign bitMask = dataWidth'(1) << bitIndex;

	always_comb begin
		nextResult = operandA;
		zeroSrc = operandA;
		nFlag = 1'b0;
		hFlag = 1'b0;
		cFlag = 1'b0;
		flagMask = '1;
		case (op)
			opAdd, opAdc, opSub, opSbc, opCp: begin
				nextResult = (op == opCp) ? operandA : sum;	// CP discards the difference
				zeroSrc = sum;
				nFlag = subtract;
				hFlag = carries[4] ^ subtract;	// Borrow is inverted carry
				cFlag = carries[dataWidth] ^ subtract;
			end
			opAnd: begin
				nextResult = operandA & operandB;
				zeroSrc = nextResult;
				hFlag = 1'b1;
			end
			opXor: begin
				nextResult = operandA ^ operandB;
				zeroSrc = nextResult;
			end
			opOr: begin
				nextResult = operandA | operandB;
				zeroSrc = nextResult;
			end
			opRlc: {cFlag, nextResult} = {operandB[7], operandB[6:0], operandB[7]};
			opRrc: {cFlag, nextResult} = {operandB[0], operandB[0], operandB[7:1]};
			opRl: {cFlag, nextResult} = {operandB[7], operandB[6:0], carry};
			opRr: {cFlag, nextResult} = {operandB[0], carry, operandB[7:1]};
			opSla: {cFlag, nextResult} = {operandB[7], operandB[6:0], 1'b0};
			opSra: {cFlag, nextResult} = {operandB[0], operandB[7], operandB[7:1]};
			opSwap: nextResult = {operandB[3:0], operandB[7:4]};
			opSrl: {cFlag, nextResult} = {operandB[0], 1'b0, operandB[7:1]};
			opBit: begin
				nextResult = operandB;
				zeroSrc = operandB & bitMask;	// Z = tested bit clear
				hFlag = 1'b1;
				cFlag = carry;
				flagMask[flagC] = 1'b0;
			end
			opRes: begin
				nextResult = operandB & ~bitMask;
				flagMask = '0;
			end
			opSet: begin
				nextResult = operandB | bitMask;
				flagMask = '0;
			end
			default: flagMask = '0;	// opNone passes A
		endcase
		// Rotates and shifts take Z from their own result
		if (op inside {opRlc, opRrc, opRl, opRr, opSla, opSra, opSwap, opSrl})
			zeroSrc = nextResult;
	end

	always_comb begin
		nextFlags = '0;
		nextFlags[flagZ] = ~|zeroSrc;
		nextFlags[flagN] = nFlag;
		nextFlags[flagH] = hFlag;
		nextFlags[flagC] = cFlag;
	end

	// Lookahead pair must agree with a plain ripple add of the same terms
	assign sumCheck = {1'b0, operandA} + {1'b0, bOperand} + (dataWidth+1)'(carryIn);

	carryChainCheck: assert #0 (carries[dataWidth] == sumCheck[dataWidth])
		else $error("Lookahead carry out differs from adder");

endmodule

// ==== rtl/carryLookahead.sv ====
`timescale 1ns/1ps

// Four-bit lookahead block, true polarity carries
module carryLookahead (
	input logic [3:0] genTerm,	// Generate per bit
	input logic [3:0] propTerm,	// Propagate per bit
	input logic carryIn,
	output logic [3:0] carryOut	// Carries into bits 1..4
);

	// Each carry expanded from carryIn so no ripple through carryOut
	assign carryOut[0] = genTerm[0]
		| (propTerm[0] & carryIn);

	assign carryOut[1] = genTerm[1]
		| (propTerm[1] & genTerm[0])
		| (propTerm[1] & propTerm[0] & carryIn);

	assign carryOut[2] = genTerm[2]
		| (propTerm[2] & genTerm[1])
		| (propTerm[2] & propTerm[1] & genTerm[0])
		| (propTerm[2] & propTerm[1] & propTerm[0] & carryIn);

	assign carryOut[3] = genTerm[3]
		| (propTerm[3] & genTerm[2])
		| (propTerm[3] & propTerm[2] & genTerm[1])
		| (propTerm[3] & propTerm[2] & propTerm[1] & genTerm[0])
		| (&propTerm & carryIn);	// Whole nibble propagates

endmodule

// ==== rtl/opDecoder.sv ====
`timescale 1ns/1ps

module opDecoder import aluPkg::*; (
	input logic cbPrefix,
	input logic [dataWidth-1:0] opcode,
	output aluOp op,
	output logic [2:0] bitIndex
);

	logic [1:0] groupField;	// Opcode bits 7:6
	logic [2:0] selField;	// Opcode bits 5:3

	assign groupField = opcode[7:6];
	assign selField = opcode[5:3];
	assign bitIndex = selField;	// Only meaningful for BIT/RES/SET

	always_comb begin
		op = opNone;
		if (!cbPrefix) begin
			if (groupField == groupAlu) begin
				case (selField)
					3'd0: op = opAdd;
					3'd1: op = opAdc;
					3'd2: op = opSub;
					3'd3: op = opSbc;
					3'd4: op = opAnd;
					3'd5: op = opXor;
					3'd6: op = opOr;
					default: op = opCp;
				endcase
			end
		end else begin
			case (groupField)
				groupCbShift: begin
					case (selField)
						3'd0: op = opRlc;
						3'd1: op = opRrc;
						3'd2: op = opRl;
						3'd3: op = opRr;
						3'd4: op = opSla;
						3'd5: op = opSra;
						3'd6: op = opSwap;
						default: op = opSrl;
					endcase
				end
				groupCbBit: op = opBit;
				groupCbRes: op = opRes;
				groupCbSet: op = opSet;
				default: op = opNone;
			endcase
		end
	end

endmodule

// ==== rtl/aluPkg.sv ====
package aluPkg;

	localparam int dataWidth = 8;	// Operand and result byte
	localparam int flagWidth = 4;	// Z, N, H, C

	// Positions inside the flag vector, same order as the F register high nibble
	localparam int flagZ = 3;
	localparam int flagN = 2;
	localparam int flagH = 1;
	localparam int flagC = 0;

	// Opcode bits 7:6
	localparam logic [1:0] groupAlu = 2'b10;	// ALU group without CB prefix
	localparam logic [1:0] groupCbShift = 2'b00;	// Rotates and shifts
	localparam logic [1:0] groupCbBit = 2'b01;
	localparam logic [1:0] groupCbRes = 2'b10;
	localparam logic [1:0] groupCbSet = 2'b11;

	// Low three bits follow opcode bits 5:3 inside each group
	typedef enum logic [4:0] {
		opAdd = 5'd0,
		opAdc = 5'd1,
		opSub = 5'd2,
		opSbc = 5'd3,
		opAnd = 5'd4,
		opXor = 5'd5,
		opOr = 5'd6,
		opCp = 5'd7,
		opRlc = 5'd8,
		opRrc = 5'd9,
		opRl = 5'd10,
		opRr = 5'd11,
		opSla = 5'd12,
		opSra = 5'd13,
		opSwap = 5'd14,
		opSrl = 5'd15,
		opBit = 5'd16,
		opRes = 5'd17,
		opSet = 5'd18,
		opNone = 5'd31	// Undecoded opcode
	} aluOp;

endpackage
